//--- build.f
ddr_phy_pkg.sv
write_slot_slicer.sv
read_valid_delay.sv
rdata_valid_combiner.sv
phy_datapath_top.sv
tb_clock_gen.sv
tb_checker.sv
tb_top.sv

//--- ddr_phy_pkg.sv
// Shared sizes, types and bundles for the DDR3 PHY core-side datapath.
// All AFI buses are ordered by time slot first and DQS group second, so
// slot t of group g starts at bit (t * num_groups + g) * width.
// Modules import this package inside their bodies and use scoped names
// in their port lists.

`default_nettype none

package ddr_phy_pkg;

	localparam int num_groups = 2;
	localparam int group_dq_width = 8;
	localparam int num_slots = 4;
	localparam int num_oe_slots = 2;
	localparam int afi_rate_ratio = 2;

	// Read-valid path
	localparam int extra_vfifo_shift = 1;
	localparam int max_vfifo_offset = 3;
	localparam int read_latency_width = 5;
	localparam int history_depth = 40;
	localparam int tap_width = $clog2(history_depth);
	localparam int offset_width = $clog2(max_vfifo_offset + 1);

	typedef logic [num_slots*num_groups*group_dq_width-1:0] afi_data_t;
	typedef logic [num_slots*num_groups-1:0] afi_mask_t;
	typedef logic [num_oe_slots*num_groups-1:0] afi_group_en_t;
	typedef logic [group_dq_width-1:0] group_dq_t;

	typedef logic [read_latency_width-1:0] read_latency_t;
	typedef logic [offset_width-1:0] vfifo_offset_t;
	typedef logic [tap_width-1:0] tap_index_t;
	typedef logic [num_groups-1:0] group_mask_t;
	typedef logic [afi_rate_ratio-1:0] afi_valid_t;

	// Write request as it arrives from the controller
	typedef struct packed {
		afi_data_t data;
		afi_mask_t mask;
		afi_group_en_t wrdata_en;
		afi_group_en_t dqs_en;
		afi_group_en_t oct_ena;
	} afi_write_t;

	// One DQS group's share of an AFI write cycle
	// Element 0 of every field is time slot t0, matching the DDIO input order
	typedef struct packed {
		group_dq_t [num_slots-1:0] dq;
		logic [num_slots-1:0] mask;
		logic [num_oe_slots-1:0] oe;
		logic [num_oe_slots-1:0] dqs_en;
		logic [num_oe_slots-1:0] oct_ena;
	} group_write_t;

endpackage

`default_nettype wire

//--- phy_datapath_top.sv
// Core-side datapath of one DDR3 PHY data block, single AFI clock.
// Write requests are registered and sliced per DQS group; read enables
// are delayed per group and combined into the AFI read-valid bus.
// Instantiate this in place of the pad-level block when only the AFI
// timing behaviour is needed.

`default_nettype none

module phy_datapath_top (
	input wire logic pll_afi_clk,
	input wire logic reset_n_afi_clk,
	input wire ddr_phy_pkg::afi_write_t afi_write,
	input wire logic afi_rdata_en_full,
	input wire ddr_phy_pkg::read_latency_t seq_read_latency,
	input wire ddr_phy_pkg::group_mask_t seq_read_increment_vfifo,
	input wire logic seq_read_fifo_reset,
	output ddr_phy_pkg::group_write_t group_write [ddr_phy_pkg::num_groups],
	output ddr_phy_pkg::afi_valid_t afi_rdata_valid
);

	import ddr_phy_pkg::*;

	group_mask_t group_rdata_valid;

	write_slot_slicer u_write_slot_slicer (
		.pll_afi_clk (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.afi_write (afi_write),
		.group_write (group_write)
	);

	read_valid_delay u_read_valid_delay (
		.pll_afi_clk (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.afi_rdata_en_full (afi_rdata_en_full),
		.seq_read_latency (seq_read_latency),
		.seq_read_increment_vfifo (seq_read_increment_vfifo),
		.seq_read_fifo_reset (seq_read_fifo_reset),
		.group_rdata_valid (group_rdata_valid)
	);

	// One more register stage after the group taps
	rdata_valid_combiner u_rdata_valid_combiner (
		.pll_afi_clk (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.group_rdata_valid (group_rdata_valid),
		.afi_rdata_valid (afi_rdata_valid)
	);

endmodule

`default_nettype wire

//--- rdata_valid_combiner.sv
// Joins the per-group read-valid bits into the AFI read-valid bus.
// Data is only valid when every DQS group has it, so the groups are
// ANDed and the registered result is copied onto each AFI valid bit.

`default_nettype none

module rdata_valid_combiner (
	input wire logic pll_afi_clk,
	input wire logic reset_n_afi_clk,
	input wire ddr_phy_pkg::group_mask_t group_rdata_valid,
	output ddr_phy_pkg::afi_valid_t afi_rdata_valid
);

	import ddr_phy_pkg::*;

	logic all_valid;

	assign all_valid = &group_rdata_valid;

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			afi_rdata_valid <= '0;
		end else begin
			afi_rdata_valid <= {afi_rate_ratio{all_valid}};
		end
	end

	// The controller reads any bit of the bus, so they must never disagree
	a_valid_bits_equal: assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		(afi_rdata_valid == '0) || (afi_rdata_valid == '1)
	) else $error("afi_rdata_valid bits differ: %h", afi_rdata_valid);

endmodule

`default_nettype wire

//--- read_valid_delay.sv
// Read-valid timing for every DQS group.
// The full-rate read enable passes the fixed extra VFIFO shift and then
// a shared history line. Each group taps that line at read latency plus
// its own VFIFO offset, which the sequencer steps with increment pulses.
// A fifo reset pulse empties the line and returns all offsets to zero.

`default_nettype none

module read_valid_delay (
	input wire logic pll_afi_clk,
	input wire logic reset_n_afi_clk,
	input wire logic afi_rdata_en_full,
	input wire ddr_phy_pkg::read_latency_t seq_read_latency,
	input wire ddr_phy_pkg::group_mask_t seq_read_increment_vfifo,
	input wire logic seq_read_fifo_reset,
	output ddr_phy_pkg::group_mask_t group_rdata_valid
);

	import ddr_phy_pkg::*;

	logic [extra_vfifo_shift-1:0] vfifo_shift;
	logic [history_depth-1:0] history;
	vfifo_offset_t offset [num_groups];
	tap_index_t tap [num_groups];

	// Bit k of the history holds the enable sampled k + extra_vfifo_shift
	// edges before the current one
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			vfifo_shift <= '0;
			history <= '0;
		end else if (seq_read_fifo_reset) begin
			// The enable sampled together with the pulse is dropped as well
			vfifo_shift <= '0;
			history <= '0;
		end else begin
			for (int i = extra_vfifo_shift - 1; i > 0; i--) begin
				vfifo_shift[i] <= vfifo_shift[i-1];
			end
			vfifo_shift[0] <= afi_rdata_en_full;
			history <= {history[history_depth-2:0], vfifo_shift[extra_vfifo_shift-1]};
		end
	end

	always_comb begin
		for (int g = 0; g < num_groups; g++) begin
			tap[g] = tap_index_t'(seq_read_latency) + tap_index_t'(offset[g]);
		end
	end

	// A new offset is used by the valid computed at the next edge
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			offset <= '{default: '0};
			group_rdata_valid <= '0;
		end else if (seq_read_fifo_reset) begin
			offset <= '{default: '0};
			group_rdata_valid <= '0;
		end else begin
			for (int g = 0; g < num_groups; g++) begin
				if (seq_read_increment_vfifo[g]) begin
					if (offset[g] == vfifo_offset_t'(max_vfifo_offset)) begin
						offset[g] <= '0;
					end else begin
						offset[g] <= offset[g] + 1'b1;
					end
				end
				group_rdata_valid[g] <= history[tap[g]];
			end
		end
	end

	// Largest latency plus largest offset must still land inside the line
	for (genvar g = 0; g < num_groups; g++) begin : gen_tap_check
		a_tap_in_range: assert property (
			@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
			int'(tap[g]) < history_depth
		) else $error("group %0d tap %0d outside read-valid history", g, tap[g]);
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Compile and run the datapath testbench with Verilator.
# Exits non-zero unless the log holds the pass line.

cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_top -f build.f -Mdir "$obj" -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$obj/sim_tb" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^All checks passed$" "$log"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

//--- tb_checker.sv
// Watches the datapath ports and compares them with a reference model.
// Everything is sampled on the falling edge: inputs then hold what the
// next rising edge takes, and outputs have settled from the last one.
// Prints one line per finished test and exports the running counts.

`default_nettype none

module tb_checker (
	input wire logic pll_afi_clk,
	input wire logic reset_n_afi_clk,
	input wire ddr_phy_pkg::afi_write_t afi_write,
	input wire logic afi_rdata_en_full,
	input wire ddr_phy_pkg::read_latency_t seq_read_latency,
	input wire ddr_phy_pkg::group_mask_t seq_read_increment_vfifo,
	input wire logic seq_read_fifo_reset,
	input wire ddr_phy_pkg::group_write_t group_write [ddr_phy_pkg::num_groups],
	input wire ddr_phy_pkg::afi_valid_t afi_rdata_valid,
	input wire logic [3:0] test_num,
	input wire logic test_end,
	output int error_count,
	output int check_count
);
	timeunit 1ns;
	timeprecision 100ps;

	import ddr_phy_pkg::*;

	// Deeper than the longest lookback of latency, offset and shift
	localparam int ring_size = 64;

	logic en_ring [ring_size];
	int edge_num;
	int clear_edge;
	int offset_model [num_groups];
	group_mask_t exp_group_valid;
	afi_valid_t exp_afi_valid;
	group_write_t exp_write [num_groups];
	logic write_known;
	int test_checks;
	int test_errors;

	// Enables taken at or before the last reset or fifo reset count as 0
	function automatic logic en_at(input int e);
		if (e <= clear_edge) begin
			return 1'b0;
		end
		return en_ring[e % ring_size];
	endfunction

	function automatic group_write_t slice_group(input afi_write_t w, input int g);
		group_write_t b;
		int bit_pos;
		for (int t = 0; t < num_slots; t++) begin
			bit_pos = (t * num_groups + g) * group_dq_width;
			b.dq[t] = group_dq_t'(w.data >> bit_pos);
			b.mask[t] = w.mask[t * num_groups + g];
		end
		for (int s = 0; s < num_oe_slots; s++) begin
			b.oe[s] = w.wrdata_en[s * num_groups + g];
			b.dqs_en[s] = w.dqs_en[s * num_groups + g];
			b.oct_ena[s] = w.oct_ena[s * num_groups + g];
		end
		return b;
	endfunction

	function automatic string test_name(input logic [3:0] n);
		case (n)
			4'd1: return "reset state";
			4'd2: return "write slicing";
			4'd3: return "fixed latency";
			4'd4: return "per-group offsets";
			4'd5: return "fifo reset";
			default: return "unnamed";
		endcase
	endfunction

	task automatic compare_write(input int g);
		group_write_t got;
		group_write_t exp;
		got = group_write[g];
		exp = exp_write[g];
		// Data and mask registers have no reset, so only enables count here
		if (!write_known) begin
			got.dq = '0;
			got.mask = '0;
			exp.dq = '0;
			exp.mask = '0;
		end
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("Fail group_write[%0d] at edge %0d: got %h expected %h",
				g, edge_num, got, exp);
		end
	endtask

	initial begin
		error_count = 0;
		check_count = 0;
		test_checks = 0;
		test_errors = 0;
		edge_num = 0;
		clear_edge = 0;
		write_known = 1'b0;
		exp_group_valid = '0;
		exp_afi_valid = '0;
		for (int g = 0; g < num_groups; g++) begin
			offset_model[g] = 0;
			exp_write[g] = '0;
		end
		for (int i = 0; i < ring_size; i++) begin
			en_ring[i] = 1'b0;
		end
	end

	always @(negedge pll_afi_clk) begin
		group_mask_t next_valid;
		check_count++;
		if (afi_rdata_valid !== exp_afi_valid) begin
			error_count++;
			$display("Fail afi_rdata_valid at edge %0d: got %h expected %h",
				edge_num, afi_rdata_valid, exp_afi_valid);
		end
		for (int g = 0; g < num_groups; g++) begin
			compare_write(g);
		end

		// Model the rising edge that follows
		edge_num++;
		if (!reset_n_afi_clk) begin
			clear_edge = edge_num;
			exp_group_valid = '0;
			exp_afi_valid = '0;
			write_known = 1'b0;
			for (int g = 0; g < num_groups; g++) begin
				offset_model[g] = 0;
				exp_write[g] = '0;
			end
		end else begin
			en_ring[edge_num % ring_size] = afi_rdata_en_full;
			if (seq_read_fifo_reset) begin
				clear_edge = edge_num;
			end
			exp_afi_valid = {afi_rate_ratio{&exp_group_valid}};
			for (int g = 0; g < num_groups; g++) begin
				next_valid[g] = en_at(edge_num - 1 - extra_vfifo_shift
					- int'(seq_read_latency) - offset_model[g]);
			end
			exp_group_valid = next_valid;
			for (int g = 0; g < num_groups; g++) begin
				if (seq_read_fifo_reset) begin
					offset_model[g] = 0;
				end else if (seq_read_increment_vfifo[g]) begin
					offset_model[g] = (offset_model[g] + 1) % (max_vfifo_offset + 1);
				end
				exp_write[g] = slice_group(afi_write, g);
			end
			write_known = 1'b1;
		end

		if (test_end) begin
			$display("Test %0d %s: %0d checks, %0d errors", test_num, test_name(test_num),
				check_count - test_checks, error_count - test_errors);
			test_checks = check_count;
			test_errors = error_count;
		end
	end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
// Clock and reset source for the datapath testbench.
// Makes an 8 ns AFI clock and holds the active-low reset for 16 rising
// edges, releasing it shortly after the last one.

`default_nettype none

module tb_clock_gen (
	output logic pll_afi_clk,
	output logic reset_n_afi_clk
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int half_period = 4;
	localparam int reset_cycles = 16;

	initial begin
		pll_afi_clk = 1'b0;
		forever #half_period pll_afi_clk = ~pll_afi_clk;
	end

	initial begin
		reset_n_afi_clk = 1'b0;
		repeat (reset_cycles) @(posedge pll_afi_clk);
		#1;
		reset_n_afi_clk = 1'b1;
	end

endmodule

`default_nettype wire

//--- tb_top.sv
// Testbench top for the DDR3 PHY core-side datapath.
// Drives random AFI writes, read enables and sequencer controls from a
// fixed seed, one nanosecond after each rising edge, over five tests.
// The checker does the comparing; this module reports the outcome.

`default_nettype none

module tb_top;
	timeunit 1ns;
	timeprecision 100ps;

	import ddr_phy_pkg::*;

	localparam int unsigned rng_seed = 32'h4ed2d0c1;
	localparam int num_tests = 5;
	localparam int wait_limit = 80;

	logic pll_afi_clk;
	logic reset_n_afi_clk;
	afi_write_t afi_write;
	logic afi_rdata_en_full;
	read_latency_t seq_read_latency;
	group_mask_t seq_read_increment_vfifo;
	logic seq_read_fifo_reset;
	group_write_t group_write [num_groups];
	afi_valid_t afi_rdata_valid;
	logic [3:0] test_num;
	logic test_end;
	int error_count;
	int check_count;

	tb_clock_gen u_clock_gen (
		.pll_afi_clk (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk)
	);

	phy_datapath_top DUT (
		.pll_afi_clk (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.afi_write (afi_write),
		.afi_rdata_en_full (afi_rdata_en_full),
		.seq_read_latency (seq_read_latency),
		.seq_read_increment_vfifo (seq_read_increment_vfifo),
		.seq_read_fifo_reset (seq_read_fifo_reset),
		.group_write (group_write),
		.afi_rdata_valid (afi_rdata_valid)
	);

	tb_checker u_checker (
		.pll_afi_clk (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.afi_write (afi_write),
		.afi_rdata_en_full (afi_rdata_en_full),
		.seq_read_latency (seq_read_latency),
		.seq_read_increment_vfifo (seq_read_increment_vfifo),
		.seq_read_fifo_reset (seq_read_fifo_reset),
		.group_write (group_write),
		.afi_rdata_valid (afi_rdata_valid),
		.test_num (test_num),
		.test_end (test_end),
		.error_count (error_count),
		.check_count (check_count)
	);

	task automatic next_cycle();
		@(posedge pll_afi_clk);
		#1;
	endtask

	task automatic abort_on_timeout(input string what);
		$display("Timeout: %s did not happen within %0d cycles", what, wait_limit);
		$display("Checks failed");
		$finish;
	endtask

	task automatic finish_test();
		test_end = 1'b1;
		next_cycle();
		test_end = 1'b0;
		test_num = test_num + 4'd1;
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		while (!reset_n_afi_clk) begin
			if (n >= wait_limit) abort_on_timeout("reset release");
			next_cycle();
			n++;
		end
	endtask

	task automatic wait_valid_level(input logic level);
		int n;
		n = 0;
		while ((afi_rdata_valid == '1) != level) begin
			if (n >= wait_limit) abort_on_timeout("read valid change");
			next_cycle();
			n++;
		end
	endtask

	task automatic random_write();
		afi_write.data = afi_data_t'({$urandom(), $urandom()});
		afi_write.mask = afi_mask_t'($urandom());
		afi_write.wrdata_en = afi_group_en_t'($urandom());
		afi_write.dqs_en = afi_group_en_t'($urandom());
		afi_write.oct_ena = afi_group_en_t'($urandom());
	endtask

	// The sequencer may only change latency after this many quiet cycles
	task automatic settle_reads();
		afi_rdata_en_full = 1'b0;
		repeat (history_depth) next_cycle();
		wait_valid_level(1'b0);
	endtask

	task automatic single_read();
		afi_rdata_en_full = 1'b1;
		next_cycle();
		afi_rdata_en_full = 1'b0;
		wait_valid_level(1'b1);
	endtask

	task automatic run_reads(input int cycles, input int density, input int inc_density);
		for (int i = 0; i < cycles; i++) begin
			random_write();
			afi_rdata_en_full = (($urandom() % density) == 0);
			seq_read_increment_vfifo = '0;
			if (inc_density > 0 && ($urandom() % inc_density) == 0) begin
				seq_read_increment_vfifo = group_mask_t'($urandom());
			end
			next_cycle();
		end
		afi_rdata_en_full = 1'b0;
		seq_read_increment_vfifo = '0;
	endtask

	initial begin
		void'($urandom(rng_seed));
		// Busy inputs in the first half of reset, which must keep them off the outputs
		afi_write = '1;
		afi_rdata_en_full = 1'b1;
		seq_read_latency = '0;
		seq_read_increment_vfifo = '0;
		seq_read_fifo_reset = 1'b0;
		test_num = 4'd1;
		test_end = 1'b0;

		repeat (8) next_cycle();
		afi_write = '0;
		afi_rdata_en_full = 1'b0;
		wait_reset_release();
		repeat (4) next_cycle();
		finish_test();

		repeat (200) begin
			random_write();
			next_cycle();
		end
		finish_test();

		repeat (4) begin
			settle_reads();
			seq_read_latency = read_latency_t'($urandom());
			single_read();
			run_reads(120, 6, 0);
		end
		finish_test();

		settle_reads();
		seq_read_latency = read_latency_t'($urandom() % 20);
		run_reads(400, 3, 12);
		finish_test();

		// Offsets are left scattered before the pulse
		run_reads(40, 2, 6);
		seq_read_fifo_reset = 1'b1;
		next_cycle();
		seq_read_fifo_reset = 1'b0;
		repeat (history_depth + 8) next_cycle();
		single_read();
		run_reads(100, 4, 0);
		finish_test();

		$display("Tests %0d, checks %0d, errors %0d", num_tests, check_count, error_count);
		if (error_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- write_slot_slicer.sv
// Core-to-periphery register for the AFI write bus.
// The registered bus is cut into one bundle per DQS group with the
// slot-major rule, ready for the per-group output DDIO stages.
// Latency from afi_write to group_write is one clock.

`default_nettype none

module write_slot_slicer (
	input wire logic pll_afi_clk,
	input wire logic reset_n_afi_clk,
	input wire ddr_phy_pkg::afi_write_t afi_write,
	output ddr_phy_pkg::group_write_t group_write [ddr_phy_pkg::num_groups]
);

	import ddr_phy_pkg::*;

	afi_data_t data_q;
	afi_mask_t mask_q;
	afi_group_en_t wrdata_en_q;
	afi_group_en_t dqs_en_q;
	afi_group_en_t oct_ena_q;

	always_ff @(posedge pll_afi_clk) begin
		data_q <= afi_write.data;
		mask_q <= afi_write.mask;
	end

	// The enables must come out of reset low so the pads stay tristated
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			wrdata_en_q <= '0;
			dqs_en_q <= '0;
			oct_ena_q <= '0;
		end else begin
			wrdata_en_q <= afi_write.wrdata_en;
			dqs_en_q <= afi_write.dqs_en;
			oct_ena_q <= afi_write.oct_ena;
		end
	end

	for (genvar g = 0; g < num_groups; g++) begin : gen_group
		group_write_t bundle;

		always_comb begin
			for (int t = 0; t < num_slots; t++) begin
				bundle.dq[t] = data_q[(t*num_groups + g)*group_dq_width +: group_dq_width];
				bundle.mask[t] = mask_q[t*num_groups + g];
			end
			// Enables are only two slots wide, one per full-rate cycle
			for (int s = 0; s < num_oe_slots; s++) begin
				bundle.oe[s] = wrdata_en_q[s*num_groups + g];
				bundle.dqs_en[s] = dqs_en_q[s*num_groups + g];
				bundle.oct_ena[s] = oct_ena_q[s*num_groups + g];
			end
		end

		assign group_write[g] = bundle;
	end

	// An X on an enable would drive the DQ pads to an unknown state
	a_enables_known: assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		!$isunknown({wrdata_en_q, dqs_en_q, oct_ena_q})
	) else $error("write enables unknown after reset");

endmodule

`default_nettype wire
